/* compile.f */
+incdir+design
design/wb_pkg.sv
design/pipe_stage.sv
design/exu.sv
design/lsu.sv
design/csr_file.sv
design/mem_wb.sv
design/backend_top.sv
testbench/backend_props.sv
testbench/backend_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the backend testbench with Verilator, then run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module backend_tb -Mdir obj_dir -o Vbackend_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit $status
fi

./obj_dir/Vbackend_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
fi
exit $status

/* testbench/backend_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_consts.svh"

module backend_tb;

    localparam int num_uops       = 400;
    localparam int stream_uops    = 100;
    localparam int timeout_cycles = num_uops * 8 + 50;

    typedef logic [`WB_DMEM_DEPTH-1:0][`WB_XLEN-1:0] dmem_img_t;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            uop_valid_i;
    logic            uop_ready_o;
    wb_pkg::uop_t    uop_i;
    logic            commit_valid_o;
    logic            commit_ready_i;
    wb_pkg::wb_t     commit_o;

    logic [31:0]      lfsr_q;
    logic [63:0]      pc_next;
    dmem_img_t        mem_m;
    wb_pkg::csr_arr_t csr_m;
    wb_pkg::wb_t      exp_q[$];
    int               hs_q[$];   // Handshake cycle, or -1 when latency is not checked.
    int               cyc;
    int               committed;
    logic             in_fire;
    logic             strict_mode;
    logic             random_ready;

    backend_top u_backend_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .uop_valid_i    (uop_valid_i),
        .uop_ready_o    (uop_ready_o),
        .uop_i          (uop_i),
        .commit_valid_o (commit_valid_o),
        .commit_ready_i (commit_ready_i),
        .commit_o       (commit_o)
    );

    bind backend_top backend_props u_backend_props (
        .clk            (clk),
        .rst_n          (rst_n),
        .uop_ready_i    (uop_ready_o),
        .mem_valid_i    (mem_valid),
        .commit_valid_i (commit_valid_o),
        .commit_ready_i (commit_ready_i),
        .commit_i       (commit_o)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[62:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    function automatic int csr_slot(input logic [11:0] addr);
        case (addr)
            `WB_CSR_MTVEC:   return 0;
            `WB_CSR_MEPC:    return 1;
            `WB_CSR_MSTATUS: return 2;
            `WB_CSR_MCAUSE:  return 3;
            default:         return -1;
        endcase
    endfunction

    function automatic wb_pkg::uop_t make_uop();
        wb_pkg::uop_t u;
        logic [3:0]   sel;
        logic [2:0]   pick;
        u       = '0;
        sel     = 4'(rand_bits(4) % 64'd10);
        u.op    = wb_pkg::op_e'(sel);
        u.pc    = pc_next;
        pc_next = pc_next + 64'd4;
        u.inst  = 32'(rand_bits(32));
        u.rd    = 5'(rand_bits(5));
        u.src1  = rand_bits(64);
        u.src2  = rand_bits(64);
        if (u.op == wb_pkg::OP_LD || u.op == wb_pkg::OP_SD) begin
            u.src1 = rand_bits(4) << 3;  // Only a few words are used so loads often hit stores.
            u.imm  = rand_bits(3) << 3;
        end
        pick = 3'(rand_bits(3));
        case (pick)
            3'd0, 3'd4: u.csr_addr = `WB_CSR_MTVEC;
            3'd1, 3'd5: u.csr_addr = `WB_CSR_MEPC;
            3'd2, 3'd6: u.csr_addr = `WB_CSR_MSTATUS;
            3'd3:       u.csr_addr = `WB_CSR_MCAUSE;
            default:    u.csr_addr = 12'h344;  // An unimplemented CSR reads zero.
        endcase
        return u;
    endfunction

    function automatic wb_pkg::wb_t model_commit(input wb_pkg::uop_t u,
                                                 inout dmem_img_t mem_img,
                                                 inout wb_pkg::csr_arr_t csr_img);
        wb_pkg::wb_t w;
        logic [63:0] addr;
        logic [63:0] old;
        int          slot;
        w       = '0;
        w.pc    = u.pc;
        w.inst  = u.inst;
        w.waddr = u.rd;
        addr    = u.src1 + u.imm;
        slot    = csr_slot(u.csr_addr);
        old     = (slot >= 0) ? csr_img[slot[1:0]] : '0;
        case (u.op)
            wb_pkg::OP_ADD:   w.wdata = u.src1 + u.src2;
            wb_pkg::OP_SUB:   w.wdata = u.src1 - u.src2;
            wb_pkg::OP_AND:   w.wdata = u.src1 & u.src2;
            wb_pkg::OP_OR:    w.wdata = u.src1 | u.src2;
            wb_pkg::OP_XOR:   w.wdata = u.src1 ^ u.src2;
            wb_pkg::OP_SLL:   w.wdata = u.src1 << u.src2[5:0];
            wb_pkg::OP_LD:    w.wdata = mem_img[addr[8:3]];
            wb_pkg::OP_SD:    mem_img[addr[8:3]] = u.src2;
            default: begin
                w.wdata = old;
                if (slot >= 0) begin
                    csr_img[slot[1:0]] = (u.op == wb_pkg::OP_CSRRW) ? u.src1 : (old | u.src1);
                end
            end
        endcase
        w.we = (u.op != wb_pkg::OP_SD) && (u.rd != 5'd0);
        if (!w.we) begin
            w.wdata = '0;
        end
        w.csr_diff = csr_img;
        return w;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
        if (got !== want) begin
            abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_commit(input wb_pkg::wb_t got, input wb_pkg::wb_t want);
        compare_field("commit_o.pc", got.pc, want.pc);
        compare_field("commit_o.inst", 64'(got.inst), 64'(want.inst));
        compare_field("commit_o.we", 64'(got.we), 64'(want.we));
        compare_field("commit_o.waddr", 64'(got.waddr), 64'(want.waddr));
        compare_field("commit_o.wdata", got.wdata, want.wdata);
        compare_field("commit_o.csr_diff.mtvec", got.csr_diff[0], want.csr_diff[0]);
        compare_field("commit_o.csr_diff.mepc", got.csr_diff[1], want.csr_diff[1]);
        compare_field("commit_o.csr_diff.mstatus", got.csr_diff[2], want.csr_diff[2]);
        compare_field("commit_o.csr_diff.mcause", got.csr_diff[3], want.csr_diff[3]);
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        compare_field(name, 64'(got), 64'(want));
    endtask

    task automatic step_ready();
        commit_ready_i = random_ready ? (rand_bits(2) != 64'd0) : 1'b1;
    endtask

    task automatic drive_uops(input int count, input bit gaps);
        int issued;
        issued = 0;
        while (issued < count) begin
            @(negedge clk);
            step_ready();
            if (uop_valid_i && in_fire) begin
                issued++;
                uop_valid_i = 1'b0;
            end
            if (issued < count && !uop_valid_i && (!gaps || rand_bits(2) != 64'd0)) begin
                uop_i       = make_uop();
                uop_valid_i = 1'b1;
            end
        end
    endtask

    task automatic drain_pipe();
        random_ready   = 1'b0;
        commit_ready_i = 1'b1;
        // With the consumer held ready the last uop commits two edges after its handshake.
        repeat (2) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cycles) begin
            abort_run($sformatf("timeout after %0d cycles with %0d of %0d uops committed",
                                cyc, committed, num_uops));
        end
    end

    // Input side. Every accepted uop goes through the model in arrival order.
    always @(posedge clk) begin
        in_fire = !rst_n && uop_valid_i && uop_ready_o;
        if (!rst_n && strict_mode && uop_valid_i && !uop_ready_o) begin
            abort_run("uop_ready_o dropped while commit_ready_i was held high");
        end
        if (in_fire) begin
            exp_q.push_back(model_commit(uop_i, mem_m, csr_m));
            hs_q.push_back(strict_mode ? cyc : -1);
        end
    end

    always @(posedge clk) begin
        wb_pkg::wb_t want;
        int          hs;
        if (!rst_n && commit_valid_o && commit_ready_i) begin
            if (exp_q.size() == 0) begin
                abort_run("a commit left the DUT with no uop outstanding");
            end
            want = exp_q.pop_front();
            hs   = hs_q.pop_front();
            check_commit(commit_o, want);
            if (hs >= 0 && cyc - hs != 2) begin
                abort_run($sformatf("commit took %0d cycles after its handshake, not 2",
                                    cyc - hs));
            end
            committed++;
        end
    end

    initial begin
        lfsr_q         = 32'd67;
        pc_next        = 64'h0000_0000_8000_0000;
        mem_m          = '0;
        csr_m          = '0;
        cyc            = 0;
        committed      = 0;
        in_fire        = 1'b0;
        strict_mode    = 1'b0;
        random_ready   = 1'b0;
        rst_n          = 1'b1;
        uop_valid_i    = 1'b0;
        uop_i          = '0;
        commit_ready_i = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_flag("commit_valid_o", commit_valid_o, 1'b0);
        end
        rst_n = 1'b0;
        @(negedge clk);
        check_flag("commit_valid_o", commit_valid_o, 1'b0);

        // Back-to-back stream with an always-ready consumer.
        strict_mode = 1'b1;
        drive_uops(stream_uops, 1'b0);
        drain_pipe();

        strict_mode  = 1'b0;
        random_ready = 1'b1;
        drive_uops(num_uops - stream_uops, 1'b1);
        drain_pipe();

        if (committed == num_uops && exp_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d of %0d uops committed at the end", committed, num_uops));
        end
    end

endmodule

`default_nettype wire

/* testbench/backend_props.sv */
`timescale 1ns/100ps
`default_nettype none

module backend_props (
    input wire              clk,
    input wire              rst_n,
    input wire              uop_ready_i,
    input wire              mem_valid_i,
    input wire              commit_valid_i,
    input wire              commit_ready_i,
    input wire wb_pkg::wb_t commit_i
);

    // A stalled commit keeps valid and payload until the consumer takes it.
    commit_hold: assert property (@(posedge clk) disable iff (rst_n)
        commit_valid_i && !commit_ready_i |=> commit_valid_i && $stable(commit_i))
        else $error("commit payload or valid changed while commit_ready_i was low");

    reset_clears: assert property (@(posedge clk)
        rst_n |=> !commit_valid_i)
        else $error("commit_valid_o high in the cycle after reset");

    // Both stage registers empty means the input must be open.
    empty_ready: assert property (@(posedge clk) disable iff (rst_n)
        !mem_valid_i && !commit_valid_i |-> uop_ready_i)
        else $error("uop_ready_o low with an empty pipeline");

endmodule

`default_nettype wire

/* design/backend_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_consts.svh"

module backend_top (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 uop_valid_i,
    output logic                uop_ready_o,
    input  wire wb_pkg::uop_t   uop_i,
    output logic                commit_valid_o,
    input  wire                 commit_ready_i,
    output wb_pkg::wb_t         commit_o
);

    logic                ex_valid;
    logic                ex_ready;
    wb_pkg::ex_mem_t     ex_data;
    logic                mem_valid;
    logic                mem_ready;
    wb_pkg::ex_mem_t     mem_data;
    logic                wb_valid;
    logic                wb_ready;
    logic                we_lsu;
    logic [`WB_XLEN-1:0] wdata_lsu;
    logic                csr_req_valid;
    logic [11:0]         csr_addr;
    wb_pkg::op_e         csr_op;
    logic [`WB_XLEN-1:0] csr_src;
    logic [`WB_XLEN-1:0] csr_rdata;
    wb_pkg::csr_arr_t    csr_diff;

    exu u_exu (
        .uop_valid_i (uop_valid_i),
        .uop_ready_o (uop_ready_o),
        .uop_i       (uop_i),
        .ex_valid_o  (ex_valid),
        .ex_ready_i  (ex_ready),
        .ex_o        (ex_data)
    );

    pipe_stage #(
        .payload_t  (wb_pkg::ex_mem_t)
    ) u_ex_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (ex_valid),
        .in_ready_o  (ex_ready),
        .in_data_i   (ex_data),
        .out_valid_o (mem_valid),
        .out_ready_i (mem_ready),
        .out_data_o  (mem_data)
    );

    lsu u_lsu (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_valid_i     (mem_valid),
        .mem_ready_o     (mem_ready),
        .mem_i           (mem_data),
        .wb_valid_o      (wb_valid),
        .wb_ready_i      (wb_ready),
        .we_lsu_o        (we_lsu),
        .wdata_lsu_o     (wdata_lsu),
        .csr_req_valid_o (csr_req_valid),
        .csr_addr_o      (csr_addr),
        .csr_op_o        (csr_op),
        .csr_src_o       (csr_src)
    );

    csr_file u_csr_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (csr_req_valid),
        .req_addr_i  (csr_addr),
        .req_op_i    (csr_op),
        .req_src_i   (csr_src),
        .rdata_o     (csr_rdata),
        .diff_o      (csr_diff)
    );

    mem_wb u_mem_wb (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid_i     (wb_valid),
        .in_ready_o     (wb_ready),
        .ex_i           (mem_data),
        .we_lsu_i       (we_lsu),
        .wdata_lsu_i    (wdata_lsu),
        .csr_rdata_i    (csr_rdata),
        .csr_diff_i     (csr_diff),
        .commit_valid_o (commit_valid_o),
        .commit_ready_i (commit_ready_i),
        .commit_o       (commit_o)
    );

endmodule

`default_nettype wire

/* design/mem_wb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_consts.svh"

module mem_wb (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   in_valid_i,
    output logic                  in_ready_o,
    input  wire wb_pkg::ex_mem_t  ex_i,
    input  wire                   we_lsu_i,
    input  wire [`WB_XLEN-1:0]    wdata_lsu_i,
    input  wire [`WB_XLEN-1:0]    csr_rdata_i,
    input  wire wb_pkg::csr_arr_t csr_diff_i,
    output logic                  commit_valid_o,
    input  wire                   commit_ready_i,
    output wb_pkg::wb_t           commit_o
);

    wb_pkg::wb_t wb_d;

    always_comb begin
        wb_d.pc       = ex_i.pc;
        wb_d.inst     = ex_i.inst;
        wb_d.we       = ex_i.we_exu | we_lsu_i;
        wb_d.waddr    = ex_i.waddr;
        wb_d.csr_diff = csr_diff_i;
        // Execute results and CSR reads never overlap, so an OR merges them.
        if (ex_i.we_exu) begin
            wb_d.wdata = ex_i.wdata_exu | csr_rdata_i;
        end else if (we_lsu_i) begin
            wb_d.wdata = wdata_lsu_i;
        end else begin
            wb_d.wdata = '0;
        end
    end

    pipe_stage #(
        .payload_t  (wb_pkg::wb_t)
    ) u_wb_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (wb_d),
        .out_valid_o (commit_valid_o),
        .out_ready_i (commit_ready_i),
        .out_data_o  (commit_o)
    );

endmodule

`default_nettype wire

/* design/csr_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_consts.svh"

module csr_file (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   req_valid_i,
    input  wire [11:0]            req_addr_i,
    input  wire wb_pkg::op_e      req_op_i,
    input  wire [`WB_XLEN-1:0]    req_src_i,
    output logic [`WB_XLEN-1:0]   rdata_o,
    output wb_pkg::csr_arr_t      diff_o
);

    wb_pkg::csr_arr_t    csr_q;
    wb_pkg::csr_arr_t    csr_d;
    logic [1:0]          sel;
    logic                hit;
    logic [`WB_XLEN-1:0] old_val;

    // Slot order matches the snapshot layout.
    always_comb begin
        hit = 1'b1;
        sel = 2'd0;
        case (req_addr_i)
            `WB_CSR_MTVEC:   sel = 2'd0;
            `WB_CSR_MEPC:    sel = 2'd1;
            `WB_CSR_MSTATUS: sel = 2'd2;
            `WB_CSR_MCAUSE:  sel = 2'd3;
            default:         hit = 1'b0;
        endcase
    end

    assign old_val = hit ? csr_q[sel] : '0;
    // Zero outside a request keeps ALU results clean in the writeback merge.
    assign rdata_o = req_valid_i ? old_val : '0;

    always_comb begin
        csr_d = csr_q;
        if (req_valid_i && hit) begin
            case (req_op_i)
                wb_pkg::OP_CSRRW: csr_d[sel] = req_src_i;
                wb_pkg::OP_CSRRS: csr_d[sel] = old_val | req_src_i;
                default:          csr_d[sel] = old_val;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            csr_q <= '0;
        end else begin
            csr_q <= csr_d;
        end
    end

    assign diff_o = csr_d;  // State as it will be after this request.

endmodule

`default_nettype wire

/* design/lsu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_consts.svh"

module lsu (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   mem_valid_i,
    output logic                  mem_ready_o,
    input  wire wb_pkg::ex_mem_t  mem_i,
    output logic                  wb_valid_o,
    input  wire                   wb_ready_i,
    output logic                  we_lsu_o,
    output logic [`WB_XLEN-1:0]   wdata_lsu_o,
    output logic                  csr_req_valid_o,
    output logic [11:0]           csr_addr_o,
    output wb_pkg::op_e           csr_op_o,
    output logic [`WB_XLEN-1:0]   csr_src_o
);

    localparam int AW = $clog2(`WB_DMEM_DEPTH);

    logic [`WB_XLEN-1:0] dmem [`WB_DMEM_DEPTH];
    logic [AW-1:0]       idx;
    logic                fire;
    logic                is_csr;

    assign fire   = mem_valid_i & wb_ready_i;
    assign idx    = mem_i.mem_addr[AW+2:3];  // Word index, bits 8 to 3.
    assign is_csr = mem_i.op inside {wb_pkg::OP_CSRRW, wb_pkg::OP_CSRRS};

    assign wb_valid_o  = mem_valid_i;
    assign mem_ready_o = wb_ready_i;

    // Stores commit only on the edge the item moves on to writeback.
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < `WB_DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (fire && mem_i.op == wb_pkg::OP_SD) begin
            dmem[idx] <= mem_i.store_data;
        end
    end

    assign we_lsu_o    = (mem_i.op == wb_pkg::OP_LD) & (mem_i.waddr != 5'd0);
    assign wdata_lsu_o = dmem[idx];  // Asynchronous read.

    // The CSR side effect is tied to the same edge as the stage transfer.
    assign csr_req_valid_o = fire & is_csr;
    assign csr_addr_o      = mem_i.csr_addr;
    assign csr_op_o        = mem_i.op;
    assign csr_src_o       = mem_i.csr_src;

endmodule

`default_nettype wire

/* design/exu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_consts.svh"

module exu (
    input  wire                  uop_valid_i,
    output logic                 uop_ready_o,
    input  wire wb_pkg::uop_t    uop_i,
    output logic                 ex_valid_o,
    input  wire                  ex_ready_i,
    output wb_pkg::ex_mem_t      ex_o
);

    logic [`WB_XLEN-1:0] alu_res;
    logic                is_alu;
    logic                is_mem;
    logic                is_csr;

    assign is_alu = uop_i.op inside {wb_pkg::OP_ADD, wb_pkg::OP_SUB, wb_pkg::OP_AND,
                                     wb_pkg::OP_OR, wb_pkg::OP_XOR, wb_pkg::OP_SLL};
    assign is_mem = uop_i.op inside {wb_pkg::OP_LD, wb_pkg::OP_SD};
    assign is_csr = uop_i.op inside {wb_pkg::OP_CSRRW, wb_pkg::OP_CSRRS};

    always_comb begin
        case (uop_i.op)
            wb_pkg::OP_ADD: alu_res = uop_i.src1 + uop_i.src2;
            wb_pkg::OP_SUB: alu_res = uop_i.src1 - uop_i.src2;
            wb_pkg::OP_AND: alu_res = uop_i.src1 & uop_i.src2;
            wb_pkg::OP_OR:  alu_res = uop_i.src1 | uop_i.src2;
            wb_pkg::OP_XOR: alu_res = uop_i.src1 ^ uop_i.src2;
            wb_pkg::OP_SLL: alu_res = uop_i.src1 << uop_i.src2[5:0];
            default:        alu_res = '0;
        endcase
    end

    always_comb begin
        ex_o.pc         = uop_i.pc;
        ex_o.inst       = uop_i.inst;
        ex_o.op         = uop_i.op;
        ex_o.waddr      = uop_i.rd;
        // Writes to x0 are dropped here so later stages never see them.
        ex_o.we_exu     = (is_alu | is_csr) & (uop_i.rd != 5'd0);
        // CSR ops carry zero so the merge picks up the old CSR value.
        ex_o.wdata_exu  = is_alu ? alu_res : '0;
        ex_o.mem_addr   = is_mem ? uop_i.src1 + uop_i.imm : '0;
        ex_o.store_data = uop_i.src2;
        ex_o.csr_addr   = uop_i.csr_addr;
        ex_o.csr_src    = uop_i.src1;
    end

    // Execute is purely combinational, so the handshake goes straight through.
    assign ex_valid_o  = uop_valid_i;
    assign uop_ready_o = ex_ready_i;

endmodule

`default_nettype wire

/* design/pipe_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic [63:0]
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              in_valid_i,
    output logic             in_ready_o,
    input  wire payload_t    in_data_i,
    output logic             out_valid_o,
    input  wire              out_ready_i,
    output payload_t         out_data_o
);

    logic     full_q;
    payload_t data_q;
    logic     accept;

    // A new item fits if the slot is empty or its current item drains now.
    assign in_ready_o = ~full_q | out_ready_i;
    assign accept     = in_valid_i & in_ready_o;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            full_q <= 1'b0;
        end else if (in_ready_o) begin
            full_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = full_q;
    assign out_data_o  = data_q;

endmodule

`default_nettype wire

/* design/wb_pkg.sv */
`default_nettype none

`include "wb_consts.svh"

package wb_pkg;

    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_SLL   = 4'd5,
        OP_LD    = 4'd6,
        OP_SD    = 4'd7,
        OP_CSRRW = 4'd8,
        OP_CSRRS = 4'd9
    } op_e;

    // Snapshot order is mtvec, mepc, mstatus, mcause.
    typedef logic [`WB_NUM_CSR-1:0][`WB_XLEN-1:0] csr_arr_t;

    typedef struct packed {
        logic [`WB_XLEN-1:0] pc;
        logic [31:0]         inst;
        op_e                 op;
        logic [4:0]          rd;
        logic [`WB_XLEN-1:0] src1;
        logic [`WB_XLEN-1:0] src2;  // Second operand or store data.
        logic [`WB_XLEN-1:0] imm;
        logic [11:0]         csr_addr;
    } uop_t;

    typedef struct packed {
        logic [`WB_XLEN-1:0] pc;
        logic [31:0]         inst;
        op_e                 op;
        logic                we_exu;
        logic [4:0]          waddr;
        logic [`WB_XLEN-1:0] wdata_exu;
        logic [`WB_XLEN-1:0] mem_addr;
        logic [`WB_XLEN-1:0] store_data;
        logic [11:0]         csr_addr;
        logic [`WB_XLEN-1:0] csr_src;
    } ex_mem_t;

    typedef struct packed {
        logic [`WB_XLEN-1:0] pc;
        logic [31:0]         inst;
        logic                we;
        logic [4:0]          waddr;
        logic [`WB_XLEN-1:0] wdata;
        csr_arr_t            csr_diff;
    } wb_t;

endpackage

`default_nettype wire

/* design/wb_consts.svh */
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// Data path and address width.
`define WB_XLEN 64

// Data memory size in 64-bit words, indexed by address bits 8 to 3.
`define WB_DMEM_DEPTH 64

`define WB_NUM_CSR 4

// Machine CSR addresses.
`define WB_CSR_MTVEC   12'h305
`define WB_CSR_MEPC    12'h341
`define WB_CSR_MSTATUS 12'h300
`define WB_CSR_MCAUSE  12'h342

`endif
